// ==== hw/cart_params.svh ====
`ifndef CART_PARAMS_SVH
`define CART_PARAMS_SVH

// Bank numbers carried on the controller bus
`define CART_BANK_W         4
`define CART_BANK_CART      4'd1
`define CART_BANK_EEPROM    4'd3

`define CART_ADDR_W         26
`define CART_DATA_W         32

// Word address slices of the byte address
`define CART_ADDR_HI        12
`define CART_ADDR_LO        2
`define EEPROM_ADDR_HI      10
`define EEPROM_ADDR_LO      2

`define CART_REG_CONFIG     11'd0
`define CART_REG_VERSION    11'd1
`define CART_REG_SCRATCH    11'd2
`define CART_VERSION        32'h5343_0102

`define EEPROM_WORDS_4K     128
`define EEPROM_WORDS_16K    512

`define LED_HOLD_CYCLES     16

`endif

// ==== hw/cart_pkg.sv ====
`include "cart_params.svh"

package cart_pkg;

    // Controller request, held stable until busy is seen low
    typedef struct packed {
        logic                      request;
        logic                      write;
        logic [`CART_BANK_W-1:0]   bank;
        logic [`CART_ADDR_W-1:0]   addr;
        logic [`CART_DATA_W-1:0]   data;
    } bus_req_t;

    typedef struct packed {
        logic                      ack;
        logic [`CART_DATA_W-1:0]   data;
    } bus_rsp_t;

    // Low 4 bits of the configuration word
    typedef struct packed {
        logic rom_switch;
        logic sdram_writable;
        logic eeprom_enable;
        logic eeprom_16k_mode;
    } cart_cfg_t;

    typedef logic [`CART_ADDR_HI-`CART_ADDR_LO:0]     cart_addr_t;
    typedef logic [`EEPROM_ADDR_HI-`EEPROM_ADDR_LO:0] eeprom_addr_t;

endpackage

// ==== hw/device_arbiter.sv ====
`timescale 1ns/100ps

`include "cart_params.svh"

module device_arbiter #(
    parameter int NUM_CONTROLLERS = 2,
    parameter logic [`CART_BANK_W-1:0] DEVICE_BANK = `CART_BANK_CART,
    parameter type addr_t = logic [10:0]
) (
    input  logic                     i_clk,
    input  logic                     i_arst_n,

    input  cart_pkg::bus_req_t       i_req [NUM_CONTROLLERS],
    input  addr_t                    i_addr [NUM_CONTROLLERS],
    output logic [NUM_CONTROLLERS-1:0] o_busy,
    output cart_pkg::bus_rsp_t       o_rsp [NUM_CONTROLLERS],

    output logic                     o_dev_request,
    output logic                     o_dev_write,
    output addr_t                    o_dev_addr,
    output logic [`CART_DATA_W-1:0]  o_dev_data,
    input  logic                     i_dev_ack,
    input  logic [`CART_DATA_W-1:0]  i_dev_data
);

    localparam int OWNER_W = (NUM_CONTROLLERS > 1) ? $clog2(NUM_CONTROLLERS) : 1;

    logic [NUM_CONTROLLERS-1:0] hit;
    logic [NUM_CONTROLLERS-1:0] accept;
    logic [OWNER_W-1:0]         grant_idx;
    logic [OWNER_W-1:0]         owner;
    logic                       pending;
    logic                       blocked;

    // Outstanding transaction frees the bank in its ack cycle
    assign blocked = pending && !i_dev_ack;

    always_comb begin
        logic lower_req;
        lower_req = 1'b0;
        for (int i = 0; i < NUM_CONTROLLERS; i++) begin
            hit[i]    = i_req[i].request && (i_req[i].bank == DEVICE_BANK);
            o_busy[i] = hit[i] && (blocked || lower_req);
            lower_req = lower_req || hit[i];
        end
    end

    assign accept = hit & ~o_busy;

    // At most one accept bit is set, lowest index wins
    always_comb begin
        grant_idx = '0;
        for (int i = NUM_CONTROLLERS - 1; i >= 0; i--) begin
            if (accept[i]) begin
                grant_idx = OWNER_W'(i);
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pending       <= 1'b0;
            owner         <= '0;
            o_dev_request <= 1'b0;
        end else if (|accept) begin
            pending       <= 1'b1;
            owner         <= grant_idx;
            o_dev_request <= 1'b1;
        end else begin
            o_dev_request <= 1'b0;
            if (i_dev_ack) begin
                pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (|accept) begin
            o_dev_write <= i_req[grant_idx].write;
            o_dev_addr  <= i_addr[grant_idx];
            o_dev_data  <= i_req[grant_idx].data;
        end
    end

    // Ack goes to the owner only
    always_comb begin
        for (int i = 0; i < NUM_CONTROLLERS; i++) begin
            o_rsp[i].ack  = pending && i_dev_ack && (owner == OWNER_W'(i));
            o_rsp[i].data = i_dev_data;
        end
    end

endmodule

// ==== hw/cart_bus_fabric.sv ====
`timescale 1ns/100ps

`include "cart_params.svh"

module cart_bus_fabric (
    input  logic                     i_clk,
    input  logic                     i_arst_n,

    input  cart_pkg::bus_req_t       i_n64_req,
    output logic                     o_n64_busy,
    output cart_pkg::bus_rsp_t       o_n64_rsp,

    input  cart_pkg::bus_req_t       i_pc_req,
    output logic                     o_pc_busy,
    output cart_pkg::bus_rsp_t       o_pc_rsp,

    output logic                     o_cart_request,
    output logic                     o_cart_write,
    output cart_pkg::cart_addr_t     o_cart_addr,
    output logic [`CART_DATA_W-1:0]  o_cart_data,
    input  logic                     i_cart_ack,
    input  logic [`CART_DATA_W-1:0]  i_cart_data,

    output logic                     o_eeprom_request,
    output logic                     o_eeprom_write,
    output cart_pkg::eeprom_addr_t   o_eeprom_addr,
    output logic [`CART_DATA_W-1:0]  o_eeprom_data,
    input  logic                     i_eeprom_ack,
    input  logic [`CART_DATA_W-1:0]  i_eeprom_data,

    output logic                     o_activity
);

    import cart_pkg::*;

    localparam int NUM_CTRL = 2;

    // Index 0 is n64, index 1 is pc
    bus_req_t            req [NUM_CTRL];
    bus_rsp_t            rsp [NUM_CTRL];
    bus_rsp_t            cart_rsp [NUM_CTRL];
    bus_rsp_t            eeprom_rsp [NUM_CTRL];
    cart_addr_t          cart_addr [NUM_CTRL];
    eeprom_addr_t        eeprom_addr [NUM_CTRL];
    logic [NUM_CTRL-1:0] cart_busy;
    logic [NUM_CTRL-1:0] eeprom_busy;
    logic [NUM_CTRL-1:0] busy;
    logic [NUM_CTRL-1:0] accepted;

    assign req[0] = i_n64_req;
    assign req[1] = i_pc_req;

    always_comb begin
        for (int i = 0; i < NUM_CTRL; i++) begin
            cart_addr[i]   = req[i].addr[`CART_ADDR_HI:`CART_ADDR_LO];
            eeprom_addr[i] = req[i].addr[`EEPROM_ADDR_HI:`EEPROM_ADDR_LO];
            busy[i]        = cart_busy[i] || eeprom_busy[i];
            accepted[i]    = req[i].request && !busy[i];
            rsp[i].ack     = cart_rsp[i].ack || eeprom_rsp[i].ack;
            if (eeprom_rsp[i].ack) begin
                rsp[i].data = eeprom_rsp[i].data;
            end else if (cart_rsp[i].ack) begin
                rsp[i].data = cart_rsp[i].data;
            end else begin
                rsp[i].data = '0;
            end
        end
    end

    device_arbiter #(
        .NUM_CONTROLLERS(NUM_CTRL),
        .DEVICE_BANK(`CART_BANK_CART),
        .addr_t(cart_addr_t)
    ) u_cart_arbiter (
        .i_clk(i_clk),
        .i_arst_n(i_arst_n),
        .i_req(req),
        .i_addr(cart_addr),
        .o_busy(cart_busy),
        .o_rsp(cart_rsp),
        .o_dev_request(o_cart_request),
        .o_dev_write(o_cart_write),
        .o_dev_addr(o_cart_addr),
        .o_dev_data(o_cart_data),
        .i_dev_ack(i_cart_ack),
        .i_dev_data(i_cart_data)
    );

    device_arbiter #(
        .NUM_CONTROLLERS(NUM_CTRL),
        .DEVICE_BANK(`CART_BANK_EEPROM),
        .addr_t(eeprom_addr_t)
    ) u_eeprom_arbiter (
        .i_clk(i_clk),
        .i_arst_n(i_arst_n),
        .i_req(req),
        .i_addr(eeprom_addr),
        .o_busy(eeprom_busy),
        .o_rsp(eeprom_rsp),
        .o_dev_request(o_eeprom_request),
        .o_dev_write(o_eeprom_write),
        .o_dev_addr(o_eeprom_addr),
        .o_dev_data(o_eeprom_data),
        .i_dev_ack(i_eeprom_ack),
        .i_dev_data(i_eeprom_data)
    );

    assign o_n64_busy = busy[0];
    assign o_n64_rsp  = rsp[0];
    assign o_pc_busy  = busy[1];
    assign o_pc_rsp   = rsp[1];
    assign o_activity = |accepted;

endmodule

// ==== hw/cart_control.sv ====
`timescale 1ns/100ps

`include "cart_params.svh"

module cart_control (
    input  logic                     i_clk,
    input  logic                     i_arst_n,

    input  logic                     i_request,
    input  logic                     i_write,
    input  cart_pkg::cart_addr_t     i_address,
    input  logic [`CART_DATA_W-1:0]  i_data,
    output logic                     o_ack,
    output logic [`CART_DATA_W-1:0]  o_data,

    output cart_pkg::cart_cfg_t      o_cfg
);

    import cart_pkg::*;

    cart_cfg_t               cfg;
    logic [`CART_DATA_W-1:0] scratch;
    logic                    wr_en;

    assign wr_en = i_request && i_write;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            cfg   <= '0;
            o_ack <= 1'b0;
        end else begin
            o_ack <= i_request;
            if (wr_en && (i_address == `CART_REG_CONFIG)) begin
                cfg <= cart_cfg_t'(i_data[$bits(cart_cfg_t)-1:0]);
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (wr_en && (i_address == `CART_REG_SCRATCH)) begin
            scratch <= i_data;
        end
    end

    // Read mux, version is a constant
    always_ff @(posedge i_clk) begin
        if (i_request && !i_write) begin
            case (i_address)
                `CART_REG_CONFIG:  o_data <= `CART_DATA_W'(cfg);
                `CART_REG_VERSION: o_data <= `CART_VERSION;
                `CART_REG_SCRATCH: o_data <= scratch;
                default:           o_data <= '0;
            endcase
        end
    end

    assign o_cfg = cfg;

endmodule

// ==== hw/eeprom_memory.sv ====
`timescale 1ns/100ps

`include "cart_params.svh"

module eeprom_memory (
    input  logic                     i_clk,
    input  logic                     i_arst_n,

    input  logic                     i_request,
    input  logic                     i_write,
    input  cart_pkg::eeprom_addr_t   i_address,
    input  logic [`CART_DATA_W-1:0]  i_data,
    output logic                     o_ack,
    output logic [`CART_DATA_W-1:0]  o_data,

    input  cart_pkg::cart_cfg_t      i_cfg
);

    import cart_pkg::*;

    logic [`CART_DATA_W-1:0] mem [`EEPROM_WORDS_16K];
    eeprom_addr_t            word_addr;

    // 4k part only decodes the low 128 words
    assign word_addr = i_cfg.eeprom_16k_mode ? i_address
                     : (i_address & eeprom_addr_t'(`EEPROM_WORDS_4K - 1));

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_ack <= 1'b0;
        end else begin
            o_ack <= i_request;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_request && i_cfg.eeprom_enable) begin
            if (i_write) begin
                mem[word_addr] <= i_data;
            end
            o_data <= mem[word_addr];
        end else if (i_request) begin
            o_data <= '0;
        end
    end

endmodule

// ==== hw/cart_led.sv ====
`timescale 1ns/100ps

`include "cart_params.svh"

module cart_led (
    input  logic i_clk,
    input  logic i_arst_n,
    input  logic i_trigger,
    output logic o_led
);

    localparam int CNT_W = $clog2(`LED_HOLD_CYCLES + 1);
    localparam logic [CNT_W-1:0] HOLD = CNT_W'(`LED_HOLD_CYCLES);

    logic [CNT_W-1:0] count;

    // Retrigger restarts the hold time
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            count <= '0;
        end else if (i_trigger) begin
            count <= HOLD;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign o_led = (count != '0);

endmodule

// ==== hw/cart_top.sv ====
`timescale 1ns/100ps

`include "cart_params.svh"

module cart_top (
    input  logic               i_clk,
    input  logic               i_arst_n,

    input  cart_pkg::bus_req_t i_n64_req,
    output logic               o_n64_busy,
    output cart_pkg::bus_rsp_t o_n64_rsp,

    input  cart_pkg::bus_req_t i_pc_req,
    output logic               o_pc_busy,
    output cart_pkg::bus_rsp_t o_pc_rsp,

    output logic               o_led
);

    import cart_pkg::*;

    logic                    cart_request;
    logic                    cart_write;
    cart_addr_t              cart_addr;
    logic [`CART_DATA_W-1:0] cart_wdata;
    logic                    cart_ack;
    logic [`CART_DATA_W-1:0] cart_rdata;

    logic                    eeprom_request;
    logic                    eeprom_write;
    eeprom_addr_t            eeprom_addr;
    logic [`CART_DATA_W-1:0] eeprom_wdata;
    logic                    eeprom_ack;
    logic [`CART_DATA_W-1:0] eeprom_rdata;

    cart_cfg_t               cfg;
    logic                    activity;

    cart_bus_fabric u_fabric (
        .i_clk(i_clk),
        .i_arst_n(i_arst_n),
        .i_n64_req(i_n64_req),
        .o_n64_busy(o_n64_busy),
        .o_n64_rsp(o_n64_rsp),
        .i_pc_req(i_pc_req),
        .o_pc_busy(o_pc_busy),
        .o_pc_rsp(o_pc_rsp),
        .o_cart_request(cart_request),
        .o_cart_write(cart_write),
        .o_cart_addr(cart_addr),
        .o_cart_data(cart_wdata),
        .i_cart_ack(cart_ack),
        .i_cart_data(cart_rdata),
        .o_eeprom_request(eeprom_request),
        .o_eeprom_write(eeprom_write),
        .o_eeprom_addr(eeprom_addr),
        .o_eeprom_data(eeprom_wdata),
        .i_eeprom_ack(eeprom_ack),
        .i_eeprom_data(eeprom_rdata),
        .o_activity(activity)
    );

    cart_control u_cart_control (
        .i_clk(i_clk),
        .i_arst_n(i_arst_n),
        .i_request(cart_request),
        .i_write(cart_write),
        .i_address(cart_addr),
        .i_data(cart_wdata),
        .o_ack(cart_ack),
        .o_data(cart_rdata),
        .o_cfg(cfg)
    );

    eeprom_memory u_eeprom (
        .i_clk(i_clk),
        .i_arst_n(i_arst_n),
        .i_request(eeprom_request),
        .i_write(eeprom_write),
        .i_address(eeprom_addr),
        .i_data(eeprom_wdata),
        .o_ack(eeprom_ack),
        .o_data(eeprom_rdata),
        .i_cfg(cfg)
    );

    cart_led u_led (
        .i_clk(i_clk),
        .i_arst_n(i_arst_n),
        .i_trigger(activity),
        .o_led(o_led)
    );

endmodule

// ==== testbench/cart_top_props.sv ====
`timescale 1ns/100ps

`include "cart_params.svh"

module cart_top_props (
    input logic               i_clk,
    input logic               i_arst_n,
    input cart_pkg::bus_req_t i_n64_req,
    input logic               i_n64_busy,
    input cart_pkg::bus_rsp_t i_n64_rsp,
    input cart_pkg::bus_req_t i_pc_req,
    input logic               i_pc_busy,
    input cart_pkg::bus_rsp_t i_pc_rsp,
    input logic               i_led
);

    int   fail_count = 0;
    logic n64_acc;
    logic pc_acc;
    logic any_acc;
    logic same_bank;

    assign n64_acc   = i_n64_req.request && !i_n64_busy;
    assign pc_acc    = i_pc_req.request && !i_pc_busy;
    assign any_acc   = n64_acc || pc_acc;
    assign same_bank = i_n64_req.request && i_pc_req.request
                     && (i_n64_req.bank == i_pc_req.bank);

    // Ack two edges after acceptance, and only then
    n64_ack_latency: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        $past(n64_acc, 2) |-> i_n64_rsp.ack)
    else begin
        fail_count++;
        $error("n64 ack missing two cycles after acceptance");
    end

    n64_ack_owner: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_n64_rsp.ack |-> $past(n64_acc, 2))
    else begin
        fail_count++;
        $error("n64 got an ack it did not own");
    end

    pc_ack_latency: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        $past(pc_acc, 2) |-> i_pc_rsp.ack)
    else begin
        fail_count++;
        $error("pc ack missing two cycles after acceptance");
    end

    pc_ack_owner: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_pc_rsp.ack |-> $past(pc_acc, 2))
    else begin
        fail_count++;
        $error("pc got an ack it did not own");
    end

    // n64 wins a tie
    tie_to_n64: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        same_bank |-> i_pc_busy)
    else begin
        fail_count++;
        $error("pc not held off while n64 requests the same bank");
    end

    pc_held_off: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        $past(n64_acc) && i_pc_req.request && (i_pc_req.bank == $past(i_n64_req.bank))
        |-> i_pc_busy)
    else begin
        fail_count++;
        $error("pc not busy while n64 owns the bank");
    end

    led_rise: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        $past(any_acc) |-> i_led)
    else begin
        fail_count++;
        $error("LED dark one cycle after an acceptance");
    end

    led_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        $past(any_acc, `LED_HOLD_CYCLES) |-> i_led)
    else begin
        fail_count++;
        $error("LED went dark before its hold time");
    end

    led_rose_cause: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        $rose(i_led) |-> $past(any_acc))
    else begin
        fail_count++;
        $error("LED lit without an acceptance");
    end

    led_fall: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        $fell(i_led) |-> $past(any_acc, (`LED_HOLD_CYCLES + 1)))
    else begin
        fail_count++;
        $error("LED went dark at the wrong time after the last acceptance");
    end

endmodule

bind cart_top cart_top_props u_props (
    .i_clk(i_clk),
    .i_arst_n(i_arst_n),
    .i_n64_req(i_n64_req),
    .i_n64_busy(o_n64_busy),
    .i_n64_rsp(o_n64_rsp),
    .i_pc_req(i_pc_req),
    .i_pc_busy(o_pc_busy),
    .i_pc_rsp(o_pc_rsp),
    .i_led(o_led)
);

// ==== testbench/tb_cart_top.sv ====
`timescale 1ns/100ps

`include "cart_params.svh"

module tb_cart_top;

    import cart_pkg::*;

    localparam int         WAIT_LIMIT = 20;
    localparam logic [3:0] CART       = `CART_BANK_CART;
    localparam logic [3:0] EEPROM     = `CART_BANK_EEPROM;

    logic     clk;
    logic     arst_n;
    bus_req_t n64_req;
    bus_req_t pc_req;
    logic     n64_busy;
    logic     pc_busy;
    bus_rsp_t n64_rsp;
    bus_rsp_t pc_rsp;
    logic     led;

    integer      seed;
    int          errors;
    int          timeouts;
    int          waited;
    logic [3:0]  cfg_model;
    logic [31:0] scratch_model;
    logic [31:0] ee_model [`EEPROM_WORDS_16K];
    logic [8:0]  ee_written [$];
    logic [31:0] rnd;
    logic [31:0] wdat;
    // Acceptance time of the last request, per controller
    time         acc_time [2];

    cart_top u_dut (
        .i_clk(clk),
        .i_arst_n(arst_n),
        .i_n64_req(n64_req),
        .o_n64_busy(n64_busy),
        .o_n64_rsp(n64_rsp),
        .i_pc_req(pc_req),
        .o_pc_busy(pc_busy),
        .o_pc_rsp(pc_rsp),
        .o_led(led)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // 4k part aliases every 128 words
    function automatic logic [8:0] ee_index(input logic [10:0] word);
        if (cfg_model[0]) begin
            return word[8:0];
        end
        return {2'b00, word[6:0]};
    endfunction

    function automatic logic [31:0] expect_read(input logic [3:0] bank, input logic [10:0] word);
        if (bank == EEPROM) begin
            return cfg_model[1] ? ee_model[ee_index(word)] : 32'h0;
        end
        case (word)
            `CART_REG_CONFIG:  return {28'h0, cfg_model};
            `CART_REG_VERSION: return `CART_VERSION;
            `CART_REG_SCRATCH: return scratch_model;
            default:           return 32'h0;
        endcase
    endfunction

    task automatic update_model(input logic [3:0] bank, input logic [10:0] word,
                                input logic [31:0] data);
        if (bank == EEPROM) begin
            if (cfg_model[1]) begin
                ee_model[ee_index(word)] = data;
            end
        end else if (word == `CART_REG_CONFIG) begin
            cfg_model = data[3:0];
        end else if (word == `CART_REG_SCRATCH) begin
            scratch_model = data;
        end
    endtask

    task automatic drive_req(input int ctrl, input bus_req_t r);
        if (ctrl == 0) begin
            n64_req <= r;
        end else begin
            pc_req <= r;
        end
    endtask

    task automatic bus_access(input int ctrl, input logic wr, input logic [3:0] bank,
                              input logic [10:0] word, input logic [31:0] wdata);
        bus_req_t    r;
        string       who;
        logic        done;
        logic [31:0] rdata;
        logic [31:0] exp;
        int          count;
        r             = '0;
        r.request     = 1'b1;
        r.write       = wr;
        r.bank        = bank;
        r.addr        = {13'h0, word, 2'b00};
        r.data        = wdata;
        who           = (ctrl == 0) ? "n64" : "pc";
        rdata         = '0;
        acc_time[ctrl] = 0;
        @(posedge clk);
        drive_req(ctrl, r);
        // Hold the request while busy
        done  = 1'b0;
        count = 0;
        while (!done && count < WAIT_LIMIT) begin
            @(negedge clk);
            done = (ctrl == 0) ? !n64_busy : !pc_busy;
            @(posedge clk);
            count++;
        end
        drive_req(ctrl, '0);
        if (!done) begin
            $display("Timeout: %s request to bank %0d was never accepted", who, bank);
            timeouts++;
            return;
        end
        acc_time[ctrl] = $time;
        done           = 1'b0;
        count          = 0;
        while (!done && count < WAIT_LIMIT) begin
            @(negedge clk);
            done  = (ctrl == 0) ? n64_rsp.ack : pc_rsp.ack;
            rdata = (ctrl == 0) ? n64_rsp.data : pc_rsp.data;
            count++;
        end
        if (!done) begin
            $display("Timeout: %s never got an ack from bank %0d", who, bank);
            timeouts++;
            return;
        end
        if (wr) begin
            update_model(bank, word, wdata);
        end else begin
            exp = expect_read(bank, word);
            read_check: assert (rdata === exp) else begin
                errors++;
                $display("[ERROR] %s_rsp.data = 0x%08h, expected 0x%08h", who, rdata, exp);
            end
        end
    endtask

    task automatic write_word(input int ctrl, input logic [3:0] bank, input logic [10:0] word,
                              input logic [31:0] data);
        bus_access(ctrl, 1'b1, bank, word, data);
    endtask

    task automatic read_word(input int ctrl, input logic [3:0] bank, input logic [10:0] word);
        bus_access(ctrl, 1'b0, bank, word, 32'h0);
    endtask

    initial begin
        seed      = 32'h60a1_4ef0;
        errors    = 0;
        timeouts  = 0;
        cfg_model = '0;
        arst_n    = 1'b0;
        n64_req   = '0;
        pc_req    = '0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;

        // Cart-control registers
        read_word(0, CART, `CART_REG_VERSION);
        read_word(1, CART, `CART_REG_VERSION);
        read_word(0, CART, `CART_REG_CONFIG);
        rnd = $random(seed);
        write_word(0, CART, `CART_REG_SCRATCH, rnd);
        read_word(1, CART, `CART_REG_SCRATCH);
        write_word(1, CART, `CART_REG_CONFIG, 32'hffff_ffff);
        read_word(0, CART, `CART_REG_CONFIG);
        read_word(1, CART, 11'd5);
        read_word(0, CART, 11'h7ff);

        // EEPROM in 16k mode
        for (int i = 0; i < 16; i++) begin
            rnd  = $random(seed);
            wdat = $random(seed);
            ee_written.push_back(rnd[8:0]);
            write_word(i % 2, EEPROM, {2'b00, rnd[8:0]}, wdat);
        end
        foreach (ee_written[i]) begin
            read_word((i + 1) % 2, EEPROM, {2'b00, ee_written[i]});
        end

        // In 4k mode w and w+128 are the same word
        write_word(0, CART, `CART_REG_CONFIG, 32'h2);
        for (int i = 0; i < 4; i++) begin
            rnd  = $random(seed);
            wdat = $random(seed);
            write_word(0, EEPROM, {4'h0, rnd[6:0]}, wdat);
            read_word(1, EEPROM, {4'h0, rnd[6:0]} + 11'd128);
            wdat = $random(seed);
            write_word(1, EEPROM, {4'h0, rnd[6:0]} + 11'd384, wdat);
            read_word(0, EEPROM, {4'h0, rnd[6:0]});
        end

        // Disabled EEPROM reads zero and keeps its contents
        write_word(1, CART, `CART_REG_CONFIG, 32'h1);
        read_word(0, EEPROM, {2'b00, ee_written[0]});
        write_word(0, EEPROM, {2'b00, ee_written[0]}, 32'hdead_beef);
        read_word(1, EEPROM, {2'b00, ee_written[0]});
        write_word(0, CART, `CART_REG_CONFIG, 32'h3);
        foreach (ee_written[i]) begin
            read_word(i % 2, EEPROM, {2'b00, ee_written[i]});
        end

        // Tie on one bank where pc reads what n64 wrote
        rnd = $random(seed);
        fork
            bus_access(0, 1'b1, CART, `CART_REG_SCRATCH, rnd);
            bus_access(1, 1'b0, CART, `CART_REG_SCRATCH, 32'h0);
        join
        order_check: assert (acc_time[0] < acc_time[1]) else begin
            errors++;
            $display("pc was accepted before n64 on a shared bank");
        end

        // Different banks run side by side
        fork
            bus_access(0, 1'b0, CART, `CART_REG_VERSION, 32'h0);
            bus_access(1, 1'b0, EEPROM, {2'b00, ee_written[2]}, 32'h0);
        join
        same_cycle_a: assert (acc_time[0] == acc_time[1]) else begin
            errors++;
            $display("n64 and pc on different banks were not accepted together");
        end
        fork
            bus_access(0, 1'b0, EEPROM, {2'b00, ee_written[3]}, 32'h0);
            bus_access(1, 1'b0, CART, `CART_REG_SCRATCH, 32'h0);
        join
        same_cycle_b: assert (acc_time[0] == acc_time[1]) else begin
            errors++;
            $display("n64 and pc on different banks were not accepted together");
        end

        // LED lit now and dark once the bus is quiet
        led_on: assert (led) else begin
            errors++;
            $display("LED was dark right after a bus access");
        end
        waited = 0;
        while (led && waited < 4 * `LED_HOLD_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (led) begin
            $display("Timeout: LED never went dark after the bus went quiet");
            timeouts++;
        end

        repeat (2) @(posedge clk);
        $display("Closing report: %0d data errors, %0d timeouts, %0d property failures",
                 errors, timeouts, u_dut.u_props.fail_count);
        if (errors == 0 && timeouts == 0 && u_dut.u_props.fail_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== cart_fabric.f ====
+incdir+hw
hw/cart_pkg.sv
hw/device_arbiter.sv
hw/cart_bus_fabric.sv
hw/cart_control.sv
hw/eeprom_memory.sv
hw/cart_led.sv
hw/cart_top.sv
testbench/cart_top_props.sv
testbench/tb_cart_top.sv

// ==== Makefile ====
TOP = tb_cart_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f cart_fabric.f

run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee /dev/stderr \
		| grep -q -F '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
